/* cfg_regs.sv */
// Tile configuration registers
// Freeze bit, core id and read-only device id, with a one-entry
// response register answering one cycle after accept.

`timescale 1ns/1ps
`default_nettype none

module cfg_regs
  (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    mem_msg_if.tgt                              bus_i,
    input  logic [tile_map_pkg::DID_WIDTH-1:0]  did_i,
    output logic                                freeze_o
  );

  localparam int CORE_ID_WIDTH = 16;

  logic                                 accept;
  logic                                 wr_en;
  logic [tile_map_pkg::OFS_WIDTH-1:0]   ofs;
  mem_msg_pkg::data_t                   rd_data;

  logic                      freeze_r;
  logic [CORE_ID_WIDTH-1:0]  core_id_r;

  logic                  resp_v_r;
  mem_msg_pkg::mem_op_e  resp_opcode_r;
  mem_msg_pkg::addr_t    resp_addr_r;
  mem_msg_pkg::data_t    resp_data_r;

  assign accept = bus_i.cmd_v & bus_i.cmd_ready;
  assign wr_en  = accept & (bus_i.cmd_opcode == mem_msg_pkg::e_mem_wr);
  assign ofs    = bus_i.cmd_addr[tile_map_pkg::OFS_WIDTH-1:0];

  // Unknown offsets read as zero
  always_comb
  begin
    rd_data = '0;
    case (ofs)
      tile_map_pkg::CFG_FREEZE_OFS:  rd_data[0] = freeze_r;
      tile_map_pkg::CFG_CORE_ID_OFS: rd_data[CORE_ID_WIDTH-1:0] = core_id_r;
      tile_map_pkg::CFG_DID_OFS:     rd_data[tile_map_pkg::DID_WIDTH-1:0] = did_i;
      default:                       rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      freeze_r  <= 1'b1;
      core_id_r <= '0;
      resp_v_r  <= 1'b0;
    end
    else
    begin
      if (wr_en && ofs == tile_map_pkg::CFG_FREEZE_OFS)
        freeze_r <= bus_i.cmd_data[0];
      if (wr_en && ofs == tile_map_pkg::CFG_CORE_ID_OFS)
        core_id_r <= bus_i.cmd_data[CORE_ID_WIDTH-1:0];
      if (accept)
        resp_v_r <= 1'b1;
      else if (bus_i.resp_yumi)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_opcode_r <= bus_i.cmd_opcode;
      resp_addr_r   <= bus_i.cmd_addr;
      resp_data_r   <= wr_en ? '0 : rd_data;
    end
  end

  assign bus_i.cmd_ready   = ~resp_v_r;
  assign bus_i.resp_v      = resp_v_r;
  assign bus_i.resp_opcode = resp_opcode_r;
  assign bus_i.resp_addr   = resp_addr_r;
  assign bus_i.resp_data   = resp_data_r;

  assign freeze_o = freeze_r;

endmodule

`default_nettype wire

/* clint_timer.sv */
// Core-local interrupt timer
// Free-running 64-bit mtime with mtimecmp compare and msip bit.
// Answers each command one cycle after accept.

`timescale 1ns/1ps
`default_nettype none

module clint_timer
  (
    input  logic   clk_i,
    input  logic   arst_n_i,
    mem_msg_if.tgt bus_i,
    output logic   timer_irq_o,
    output logic   software_irq_o
  );

  logic                                 accept;
  logic                                 wr_en;
  logic [tile_map_pkg::OFS_WIDTH-1:0]   ofs;
  mem_msg_pkg::data_t                   rd_data;

  logic [63:0]           mtime_r;
  logic [63:0]           mtimecmp_r;
  logic                  msip_r;
  logic                  timer_irq_r;

  logic                  resp_v_r;
  mem_msg_pkg::mem_op_e  resp_opcode_r;
  mem_msg_pkg::addr_t    resp_addr_r;
  mem_msg_pkg::data_t    resp_data_r;

  assign accept = bus_i.cmd_v & bus_i.cmd_ready;
  assign wr_en  = accept & (bus_i.cmd_opcode == mem_msg_pkg::e_mem_wr);
  assign ofs    = bus_i.cmd_addr[tile_map_pkg::OFS_WIDTH-1:0];

  always_comb
  begin
    case (ofs)
      tile_map_pkg::CLINT_MSIP_OFS:     rd_data = {63'd0, msip_r};
      tile_map_pkg::CLINT_MTIMECMP_OFS: rd_data = mtimecmp_r;
      tile_map_pkg::CLINT_MTIME_OFS:    rd_data = mtime_r;
      default:                          rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mtime_r     <= '0;
      mtimecmp_r  <= '1;
      msip_r      <= 1'b0;
      timer_irq_r <= 1'b0;
      resp_v_r    <= 1'b0;
    end
    else
    begin
      // A write to mtime wins over the tick
      if (wr_en && ofs == tile_map_pkg::CLINT_MTIME_OFS)
        mtime_r <= bus_i.cmd_data;
      else
        mtime_r <= mtime_r + 64'd1;
      if (wr_en && ofs == tile_map_pkg::CLINT_MTIMECMP_OFS)
        mtimecmp_r <= bus_i.cmd_data;
      if (wr_en && ofs == tile_map_pkg::CLINT_MSIP_OFS)
        msip_r <= bus_i.cmd_data[0];
      timer_irq_r <= (mtime_r >= mtimecmp_r);
      if (accept)
        resp_v_r <= 1'b1;
      else if (bus_i.resp_yumi)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_opcode_r <= bus_i.cmd_opcode;
      resp_addr_r   <= bus_i.cmd_addr;
      resp_data_r   <= wr_en ? '0 : rd_data;
    end
  end

  assign bus_i.cmd_ready   = ~resp_v_r;
  assign bus_i.resp_v      = resp_v_r;
  assign bus_i.resp_opcode = resp_opcode_r;
  assign bus_i.resp_addr   = resp_addr_r;
  assign bus_i.resp_data   = resp_data_r;

  assign timer_irq_o    = timer_irq_r;
  assign software_irq_o = msip_r;

endmodule

`default_nettype wire

/* l2_slice_fsm.sv */
// Cache slice model
// Fixed-latency word memory standing in for the DRAM-backed cache
// slice. One command at a time; the answer is offered CACHE_LATENCY
// cycles after the command is accepted.

`timescale 1ns/1ps
`default_nettype none

module l2_slice_fsm
  #(
    parameter int MEM_WORDS     = 256,
    parameter int CACHE_LATENCY = 4
  )
  (
    input  logic   clk_i,
    input  logic   arst_n_i,
    mem_msg_if.tgt bus_i
  );

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int CNT_W = $clog2(CACHE_LATENCY);

  typedef enum logic [1:0]
  {
    IDLE,
    ACCESS,
    RESPOND
  } state_e;

  state_e                state_r;
  logic [CNT_W-1:0]      cnt_r;
  logic                  accept;
  logic                  last_access;

  mem_msg_pkg::data_t    mem [MEM_WORDS];
  mem_msg_pkg::mem_op_e  op_r;
  mem_msg_pkg::addr_t    addr_r;
  mem_msg_pkg::data_t    wdata_r;
  mem_msg_pkg::data_t    rdata_r;
  logic [IDX_W-1:0]      idx;

  assign accept      = bus_i.cmd_v & bus_i.cmd_ready;
  assign last_access = (state_r == ACCESS) && (cnt_r == '0);
  // Word index modulo a power-of-two MEM_WORDS
  assign idx         = addr_r[3 +: IDX_W];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r <= IDLE;
      cnt_r   <= '0;
    end
    else
    begin
      case (state_r)
        IDLE:
        begin
          if (accept)
          begin
            state_r <= ACCESS;
            cnt_r   <= CNT_W'(CACHE_LATENCY - 2);
          end
        end
        ACCESS:
        begin
          if (cnt_r == '0)
            state_r <= RESPOND;
          else
            cnt_r <= cnt_r - CNT_W'(1);
        end
        RESPOND:
        begin
          if (bus_i.resp_yumi)
            state_r <= IDLE;
        end
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      op_r    <= bus_i.cmd_opcode;
      addr_r  <= bus_i.cmd_addr;
      wdata_r <= bus_i.cmd_data;
    end
    if (last_access)
    begin
      if (op_r == mem_msg_pkg::e_mem_wr)
      begin
        mem[idx] <= wdata_r;
        rdata_r  <= '0;
      end
      else
        rdata_r <= mem[idx];
    end
  end

  assign bus_i.cmd_ready   = (state_r == IDLE);
  assign bus_i.resp_v      = (state_r == RESPOND);
  assign bus_i.resp_opcode = op_r;
  assign bus_i.resp_addr   = addr_r;
  assign bus_i.resp_data   = rdata_r;

endmodule

`default_nettype wire

/* list.f */
mem_msg_pkg.sv
tile_map_pkg.sv
mem_msg_if.sv
mem_cmd_switch.sv
l2_slice_fsm.sv
cfg_regs.sv
clint_timer.sv
tile_local_mem.sv
tile_local_mem_checker.sv
tb_tile_local_mem.sv

/* mem_cmd_switch.sv */
// Local memory command switch
// Decodes the command address, steers the command to the cache
// slice, the timer or the configuration block, and merges the
// three response streams under fixed priority.

`timescale 1ns/1ps
`default_nettype none

module mem_cmd_switch
  (
    input  logic                 cmd_v_i,
    output logic                 cmd_ready_o,
    input  mem_msg_pkg::mem_op_e cmd_opcode_i,
    input  mem_msg_pkg::addr_t   cmd_addr_i,
    input  mem_msg_pkg::data_t   cmd_data_i,
    output logic                 resp_v_o,
    input  logic                 resp_yumi_i,
    output mem_msg_pkg::mem_op_e resp_opcode_o,
    output mem_msg_pkg::addr_t   resp_addr_o,
    output mem_msg_pkg::data_t   resp_data_o,
    mem_msg_if.sw                l2_o,
    mem_msg_if.sw                cfg_o,
    mem_msg_if.sw                clint_o
  );

  logic                                local_cmd;
  logic [tile_map_pkg::DEV_WIDTH-1:0]  dev_id;
  logic                                sel_l2;
  logic                                sel_cfg;
  logic                                sel_clint;

  assign local_cmd = (cmd_addr_i < tile_map_pkg::LOCAL_LIMIT);
  assign dev_id    = cmd_addr_i[tile_map_pkg::DEV_LSB +: tile_map_pkg::DEV_WIDTH];

  // Unknown local ids fall through to the config block
  always_comb
  begin
    sel_l2    = ~local_cmd;
    sel_cfg   = 1'b0;
    sel_clint = 1'b0;
    if (local_cmd)
    begin
      case (dev_id)
        tile_map_pkg::DEV_CLINT: sel_clint = 1'b1;
        tile_map_pkg::DEV_CFG:   sel_cfg   = 1'b1;
        default:                 sel_cfg   = 1'b1;
      endcase
    end
  end

  // Fields go everywhere, valid only to the chosen target
  assign l2_o.cmd_v         = cmd_v_i & sel_l2;
  assign l2_o.cmd_opcode    = cmd_opcode_i;
  assign l2_o.cmd_addr      = cmd_addr_i;
  assign l2_o.cmd_data      = cmd_data_i;
  assign cfg_o.cmd_v        = cmd_v_i & sel_cfg;
  assign cfg_o.cmd_opcode   = cmd_opcode_i;
  assign cfg_o.cmd_addr     = cmd_addr_i;
  assign cfg_o.cmd_data     = cmd_data_i;
  assign clint_o.cmd_v      = cmd_v_i & sel_clint;
  assign clint_o.cmd_opcode = cmd_opcode_i;
  assign clint_o.cmd_addr   = cmd_addr_i;
  assign clint_o.cmd_data   = cmd_data_i;

  assign cmd_ready_o = sel_l2  ? l2_o.cmd_ready  :
                       sel_cfg ? cfg_o.cmd_ready : clint_o.cmd_ready;

  // Slice first, then config, then timer
  assign resp_v_o      = l2_o.resp_v | cfg_o.resp_v | clint_o.resp_v;
  assign resp_opcode_o = l2_o.resp_v  ? l2_o.resp_opcode  :
                         cfg_o.resp_v ? cfg_o.resp_opcode : clint_o.resp_opcode;
  assign resp_addr_o   = l2_o.resp_v  ? l2_o.resp_addr  :
                         cfg_o.resp_v ? cfg_o.resp_addr : clint_o.resp_addr;
  assign resp_data_o   = l2_o.resp_v  ? l2_o.resp_data  :
                         cfg_o.resp_v ? cfg_o.resp_data : clint_o.resp_data;

  assign l2_o.resp_yumi    = resp_yumi_i & l2_o.resp_v;
  assign cfg_o.resp_yumi   = resp_yumi_i & cfg_o.resp_v & ~l2_o.resp_v;
  assign clint_o.resp_yumi = resp_yumi_i & clint_o.resp_v & ~l2_o.resp_v & ~cfg_o.resp_v;

endmodule

`default_nettype wire

/* mem_msg_if.sv */
// Memory message bundle
// Command (valid/ready) and response (valid/yumi) signals between
// the command switch and one target.

`timescale 1ns/1ps
`default_nettype none

interface mem_msg_if;

  logic                  cmd_v;
  logic                  cmd_ready;
  mem_msg_pkg::mem_op_e  cmd_opcode;
  mem_msg_pkg::addr_t    cmd_addr;
  mem_msg_pkg::data_t    cmd_data;

  logic                  resp_v;
  logic                  resp_yumi;
  mem_msg_pkg::mem_op_e  resp_opcode;
  mem_msg_pkg::addr_t    resp_addr;
  mem_msg_pkg::data_t    resp_data;

  modport sw
  (
    output cmd_v, cmd_opcode, cmd_addr, cmd_data, resp_yumi,
    input  cmd_ready, resp_v, resp_opcode, resp_addr, resp_data
  );

  modport tgt
  (
    input  cmd_v, cmd_opcode, cmd_addr, cmd_data, resp_yumi,
    output cmd_ready, resp_v, resp_opcode, resp_addr, resp_data
  );

endinterface

`default_nettype wire

/* mem_msg_pkg.sv */
// Memory message definitions
// Opcodes and field widths shared by the command and response
// paths of the tile local memory side.

`default_nettype none

package mem_msg_pkg;

  localparam int ADDR_WIDTH = 40;
  localparam int DATA_WIDTH = 64;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Message opcodes
  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the tile local memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_tile_local_mem -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_tile_local_mem)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

/* tb_tile_local_mem.sv */
// Testbench for the tile local memory side
// Directed tests of the cache slice, configuration registers,
// interrupt timer and the fixed-priority response merge.

`timescale 1ns/1ps
`default_nettype none

module tb_tile_local_mem;

  // Whole run takes a few hundred cycles
  localparam int TIMEOUT_CYCLES  = 3000;
  localparam int RESET_CYCLES    = 8;
  localparam int IRQ_WAIT_CYCLES = 60;
  localparam int SLICE_WORDS     = 6;

  localparam logic [tile_map_pkg::DID_WIDTH-1:0] DID_VALUE = 16'h2A5C;
  localparam mem_msg_pkg::data_t CORE_ID_VALUE = 64'h0000_0000_0000_BEEF;

  // Device 2 is config, device 1 the timer, 7 and F are unmapped
  localparam mem_msg_pkg::addr_t CFG_FREEZE_A     = 40'h00_0020_0000;
  localparam mem_msg_pkg::addr_t CFG_CORE_ID_A    = 40'h00_0020_0008;
  localparam mem_msg_pkg::addr_t CFG_DID_A        = 40'h00_0020_0010;
  localparam mem_msg_pkg::addr_t ODD_CORE_ID_A    = 40'h00_00F0_0008;
  localparam mem_msg_pkg::addr_t ODD_UNKNOWN_A    = 40'h00_0070_0024;
  localparam mem_msg_pkg::addr_t CLINT_MSIP_A     = 40'h00_0010_0000;
  localparam mem_msg_pkg::addr_t CLINT_MTIMECMP_A = 40'h00_0010_4000;
  localparam mem_msg_pkg::addr_t CLINT_MTIME_A    = 40'h00_0010_BFF8;

  logic                                clk;
  logic                                arst_n;
  logic [tile_map_pkg::DID_WIDTH-1:0]  did;
  logic                                cmd_v;
  logic                                cmd_ready;
  mem_msg_pkg::mem_op_e                cmd_opcode;
  mem_msg_pkg::addr_t                  cmd_addr;
  mem_msg_pkg::data_t                  cmd_data;
  logic                                resp_v;
  logic                                resp_yumi;
  mem_msg_pkg::mem_op_e                resp_opcode;
  mem_msg_pkg::addr_t                  resp_addr;
  mem_msg_pkg::data_t                  resp_data;
  logic                                freeze;
  logic                                timer_irq;
  logic                                software_irq;

  int error_count = 0;
  int check_count = 0;
  int test_count  = 0;
  int cycle_count = 0;

  mem_msg_pkg::addr_t slice_addr [SLICE_WORDS];
  mem_msg_pkg::data_t slice_data [SLICE_WORDS];

  tile_local_mem i_dut
  (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .did_i          (did),
    .cmd_v_i        (cmd_v),
    .cmd_ready_o    (cmd_ready),
    .cmd_opcode_i   (cmd_opcode),
    .cmd_addr_i     (cmd_addr),
    .cmd_data_i     (cmd_data),
    .resp_v_o       (resp_v),
    .resp_yumi_i    (resp_yumi),
    .resp_opcode_o  (resp_opcode),
    .resp_addr_o    (resp_addr),
    .resp_data_o    (resp_data),
    .freeze_o       (freeze),
    .timer_irq_o    (timer_irq),
    .software_irq_o (software_irq)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, a handshake never completed", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("MISMATCH %s: expected 0x%0h got 0x%0h", name, exp, got);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic got);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("MISMATCH %s: expected 0x%0h got 0x%0h", name, exp, got);
    end
  endtask

  // Holds the command until the addressed target is ready
  task automatic send_cmd(input mem_msg_pkg::mem_op_e op, input mem_msg_pkg::addr_t addr,
                          input mem_msg_pkg::data_t data);
    cmd_v      = 1'b1;
    cmd_opcode = op;
    cmd_addr   = addr;
    cmd_data   = data;
    @(negedge clk);
    while (!cmd_ready)
      @(negedge clk);
    next_cycle();
    cmd_v = 1'b0;
  endtask

  task automatic collect_resp(input mem_msg_pkg::mem_op_e op, input mem_msg_pkg::addr_t addr,
                              input mem_msg_pkg::data_t data, input bit check_data,
                              output mem_msg_pkg::data_t got);
    @(negedge clk);
    while (!resp_v)
      @(negedge clk);
    got = resp_data;
    compare_value("resp_opcode_o", 64'(op), 64'(resp_opcode));
    compare_value("resp_addr_o", 64'(addr), 64'(resp_addr));
    if (check_data)
      compare_value("resp_data_o", data, resp_data);
    next_cycle();
    resp_yumi = 1'b1;
    next_cycle();
    resp_yumi = 1'b0;
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before)
      $display("%s: done, no errors", name);
    else
      $display("%s: done, %0d errors", name, error_count - errors_before);
  endtask

  task automatic test_reset_state();
    int errs;
    errs = error_count;
    @(negedge clk);
    compare_bit("freeze_o", 1'b1, freeze);
    compare_bit("timer_irq_o", 1'b0, timer_irq);
    compare_bit("software_irq_o", 1'b0, software_irq);
    compare_bit("resp_v_o", 1'b0, resp_v);
    compare_bit("cmd_ready_o", 1'b1, cmd_ready);
    next_cycle();
    report_test("reset_state", errs);
  endtask

  task automatic test_slice_memory();
    int errs;
    mem_msg_pkg::data_t got;
    errs = error_count;
    slice_addr[0] = 40'h00_8000_0000;
    slice_addr[1] = 40'h00_8000_0008;
    slice_addr[2] = 40'h00_8000_0100;
    slice_addr[3] = 40'h00_C000_0040;
    slice_addr[4] = 40'h01_0000_0200;
    slice_addr[5] = 40'hFF_0000_0338;
    for (int i = 0; i < SLICE_WORDS; i++)
    begin
      slice_data[i] = {$urandom, $urandom};
      send_cmd(mem_msg_pkg::e_mem_wr, slice_addr[i], slice_data[i]);
      collect_resp(mem_msg_pkg::e_mem_wr, slice_addr[i], 64'd0, 1'b1, got);
    end
    for (int i = 0; i < SLICE_WORDS; i++)
    begin
      send_cmd(mem_msg_pkg::e_mem_rd, slice_addr[i], 64'd0);
      collect_resp(mem_msg_pkg::e_mem_rd, slice_addr[i], slice_data[i], 1'b1, got);
    end
    report_test("slice_memory", errs);
  endtask

  task automatic test_config_regs();
    int errs;
    mem_msg_pkg::data_t got;
    errs = error_count;
    send_cmd(mem_msg_pkg::e_mem_wr, CFG_FREEZE_A, 64'd0);
    collect_resp(mem_msg_pkg::e_mem_wr, CFG_FREEZE_A, 64'd0, 1'b1, got);
    compare_bit("freeze_o", 1'b0, freeze);
    send_cmd(mem_msg_pkg::e_mem_wr, CFG_CORE_ID_A, CORE_ID_VALUE);
    collect_resp(mem_msg_pkg::e_mem_wr, CFG_CORE_ID_A, 64'd0, 1'b1, got);
    send_cmd(mem_msg_pkg::e_mem_rd, CFG_CORE_ID_A, 64'd0);
    collect_resp(mem_msg_pkg::e_mem_rd, CFG_CORE_ID_A, CORE_ID_VALUE, 1'b1, got);
    send_cmd(mem_msg_pkg::e_mem_rd, CFG_DID_A, 64'd0);
    collect_resp(mem_msg_pkg::e_mem_rd, CFG_DID_A, {48'd0, DID_VALUE}, 1'b1, got);
    // Unmapped device ids land in the config block
    send_cmd(mem_msg_pkg::e_mem_rd, ODD_CORE_ID_A, 64'd0);
    collect_resp(mem_msg_pkg::e_mem_rd, ODD_CORE_ID_A, CORE_ID_VALUE, 1'b1, got);
    send_cmd(mem_msg_pkg::e_mem_rd, ODD_UNKNOWN_A, 64'd0);
    collect_resp(mem_msg_pkg::e_mem_rd, ODD_UNKNOWN_A, 64'd0, 1'b1, got);
    report_test("config_regs", errs);
  endtask

  task automatic test_timer();
    int errs;
    int waited;
    mem_msg_pkg::data_t got;
    mem_msg_pkg::data_t t1;
    mem_msg_pkg::data_t t2;
    errs = error_count;
    send_cmd(mem_msg_pkg::e_mem_wr, CLINT_MSIP_A, 64'd1);
    collect_resp(mem_msg_pkg::e_mem_wr, CLINT_MSIP_A, 64'd0, 1'b1, got);
    compare_bit("software_irq_o", 1'b1, software_irq);
    send_cmd(mem_msg_pkg::e_mem_wr, CLINT_MSIP_A, 64'd0);
    collect_resp(mem_msg_pkg::e_mem_wr, CLINT_MSIP_A, 64'd0, 1'b1, got);
    compare_bit("software_irq_o", 1'b0, software_irq);
    send_cmd(mem_msg_pkg::e_mem_rd, CLINT_MTIME_A, 64'd0);
    collect_resp(mem_msg_pkg::e_mem_rd, CLINT_MTIME_A, 64'd0, 1'b0, t1);
    send_cmd(mem_msg_pkg::e_mem_rd, CLINT_MTIME_A, 64'd0);
    collect_resp(mem_msg_pkg::e_mem_rd, CLINT_MTIME_A, 64'd0, 1'b0, t2);
    check_count++;
    if (!(t2 > t1))
    begin
      error_count++;
      $display("mtime did not advance between reads, 0x%0h then 0x%0h", t1, t2);
    end
    send_cmd(mem_msg_pkg::e_mem_wr, CLINT_MTIMECMP_A, t2 + 64'd20);
    collect_resp(mem_msg_pkg::e_mem_wr, CLINT_MTIMECMP_A, 64'd0, 1'b1, got);
    compare_bit("timer_irq_o", 1'b0, timer_irq);
    waited = 0;
    @(negedge clk);
    while (!timer_irq && waited < IRQ_WAIT_CYCLES)
    begin
      @(negedge clk);
      waited++;
    end
    check_count++;
    if (!timer_irq)
    begin
      error_count++;
      $display("timer_irq_o did not rise within %0d cycles of the mtimecmp write",
               IRQ_WAIT_CYCLES);
    end
    next_cycle();
    report_test("timer", errs);
  endtask

  task automatic test_response_priority();
    int errs;
    mem_msg_pkg::data_t got;
    errs = error_count;
    // Yumi stays low until all three responses wait
    send_cmd(mem_msg_pkg::e_mem_wr, CLINT_MSIP_A, 64'd1);
    send_cmd(mem_msg_pkg::e_mem_wr, CFG_CORE_ID_A, 64'h55AA);
    send_cmd(mem_msg_pkg::e_mem_rd, slice_addr[3], 64'd0);
    repeat (10)
      next_cycle();
    collect_resp(mem_msg_pkg::e_mem_rd, slice_addr[3], slice_data[3], 1'b1, got);
    collect_resp(mem_msg_pkg::e_mem_wr, CFG_CORE_ID_A, 64'd0, 1'b1, got);
    collect_resp(mem_msg_pkg::e_mem_wr, CLINT_MSIP_A, 64'd0, 1'b1, got);
    @(negedge clk);
    compare_bit("resp_v_o", 1'b0, resp_v);
    next_cycle();
    report_test("response_priority", errs);
  endtask

  initial
  begin
    void'($urandom(25991));
    arst_n     = 1'b0;
    did        = DID_VALUE;
    cmd_v      = 1'b0;
    cmd_opcode = mem_msg_pkg::e_mem_rd;
    cmd_addr   = '0;
    cmd_data   = '0;
    resp_yumi  = 1'b0;
    repeat (RESET_CYCLES)
      @(posedge clk);
    #1;
    arst_n = 1'b1;
    test_reset_state();
    test_slice_memory();
    test_config_regs();
    test_timer();
    test_response_priority();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* tile_local_mem.sv */
// Tile local memory side
// One command port and one response port in front of the cache
// slice, the configuration registers and the interrupt timer.

`timescale 1ns/1ps
`default_nettype none

module tile_local_mem
  #(
    parameter int MEM_WORDS     = 256,
    parameter int CACHE_LATENCY = 4
  )
  (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic [tile_map_pkg::DID_WIDTH-1:0]  did_i,
    input  logic                                cmd_v_i,
    output logic                                cmd_ready_o,
    input  mem_msg_pkg::mem_op_e                cmd_opcode_i,
    input  mem_msg_pkg::addr_t                  cmd_addr_i,
    input  mem_msg_pkg::data_t                  cmd_data_i,
    output logic                                resp_v_o,
    input  logic                                resp_yumi_i,
    output mem_msg_pkg::mem_op_e                resp_opcode_o,
    output mem_msg_pkg::addr_t                  resp_addr_o,
    output mem_msg_pkg::data_t                  resp_data_o,
    output logic                                freeze_o,
    output logic                                timer_irq_o,
    output logic                                software_irq_o
  );

  mem_msg_if to_l2 ();
  mem_msg_if to_cfg ();
  mem_msg_if to_clint ();

  mem_cmd_switch i_switch
  (
    .cmd_v_i       (cmd_v_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_opcode_i  (cmd_opcode_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_data_i    (cmd_data_i),
    .resp_v_o      (resp_v_o),
    .resp_yumi_i   (resp_yumi_i),
    .resp_opcode_o (resp_opcode_o),
    .resp_addr_o   (resp_addr_o),
    .resp_data_o   (resp_data_o),
    .l2_o          (to_l2.sw),
    .cfg_o         (to_cfg.sw),
    .clint_o       (to_clint.sw)
  );

  l2_slice_fsm
  #(
    .MEM_WORDS     (MEM_WORDS),
    .CACHE_LATENCY (CACHE_LATENCY)
  )
  i_l2
  (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus_i    (to_l2.tgt)
  );

  cfg_regs i_cfg
  (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus_i    (to_cfg.tgt),
    .did_i    (did_i),
    .freeze_o (freeze_o)
  );

  clint_timer i_clint
  (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .bus_i          (to_clint.tgt),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

endmodule

`default_nettype wire

/* tile_local_mem_checker.sv */
// Response port checks for the tile local memory
// A waiting response holds until yumi, yumi needs a valid response,
// and the software interrupt stays low during reset.

`timescale 1ns/1ps
`default_nettype none

module tile_local_mem_checker
  (
    input logic                 clk_i,
    input logic                 arst_n_i,
    input logic                 resp_v_i,
    input logic                 resp_yumi_i,
    input mem_msg_pkg::mem_op_e resp_opcode_i,
    input mem_msg_pkg::addr_t   resp_addr_i,
    input mem_msg_pkg::data_t   resp_data_i,
    input logic                 software_irq_i
  );

  // Priority rank of the offered response, 0 is the cache slice
  logic [1:0] resp_rank;

  always_comb
  begin
    if (resp_addr_i >= tile_map_pkg::LOCAL_LIMIT)
      resp_rank = 2'd0;
    else if (resp_addr_i[tile_map_pkg::DEV_LSB +: tile_map_pkg::DEV_WIDTH]
             == tile_map_pkg::DEV_CLINT)
      resp_rank = 2'd2;
    else
      resp_rank = 2'd1;
  end

  // Fields may only change when a higher-priority response takes the port
  a_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_i && !resp_yumi_i |=> resp_v_i &&
      (($stable(resp_opcode_i) && $stable(resp_addr_i) && $stable(resp_data_i)) ||
       (resp_rank < $past(resp_rank))))
    else $error("response dropped or changed before yumi");

  a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_yumi_i |-> resp_v_i)
    else $error("resp_yumi_i high without resp_v_o");

  a_swirq_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> !software_irq_i)
    else $error("software_irq_o high during reset");

endmodule

bind tile_local_mem tile_local_mem_checker i_checker
(
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .resp_v_i       (resp_v_o),
  .resp_yumi_i    (resp_yumi_i),
  .resp_opcode_i  (resp_opcode_o),
  .resp_addr_i    (resp_addr_o),
  .resp_data_i    (resp_data_o),
  .software_irq_i (software_irq_o)
);

`default_nettype wire

/* tile_map_pkg.sv */
// Tile local memory map
// Local boundary, device id field and register offsets of the
// configuration block and the interrupt timer.

`default_nettype none

package tile_map_pkg;

  // Addresses at or above this go to the cache slice
  localparam mem_msg_pkg::addr_t LOCAL_LIMIT = 40'h00_8000_0000;

  localparam int DEV_LSB   = 20;
  localparam int DEV_WIDTH = 4;
  localparam logic [DEV_WIDTH-1:0] DEV_CLINT = 4'd1;
  localparam logic [DEV_WIDTH-1:0] DEV_CFG   = 4'd2;

  localparam int OFS_WIDTH = 20;
  localparam logic [OFS_WIDTH-1:0] CFG_FREEZE_OFS     = 20'h0_0000;
  localparam logic [OFS_WIDTH-1:0] CFG_CORE_ID_OFS    = 20'h0_0008;
  localparam logic [OFS_WIDTH-1:0] CFG_DID_OFS        = 20'h0_0010;
  localparam logic [OFS_WIDTH-1:0] CLINT_MSIP_OFS     = 20'h0_0000;
  localparam logic [OFS_WIDTH-1:0] CLINT_MTIMECMP_OFS = 20'h0_4000;
  localparam logic [OFS_WIDTH-1:0] CLINT_MTIME_OFS    = 20'h0_BFF8;

  localparam int DID_WIDTH = 16;

endpackage

`default_nettype wire
